/* source/uma_settings.svh */
// UMA arbiter settings for bus widths and the slot schedule
`ifndef UMA_SETTINGS_SVH
`define UMA_SETTINGS_SVH

// Shared RAM bus widths
`define UMA_ADDR_W 24
`define UMA_DATA_W 32
`define UMA_SIZE_W 2

// System clocks per CLK_EN period
`define UMA_DIV 30

// Count at which the first slot of a period opens
`define UMA_SLOT_OFFSET 2

// Clocks from a slot strobe to its execution point
`define UMA_EXEC_DELAY 2

`endif

/* source/uma_pkg.sv */
// UMA arbiter types for RAM commands, responses and channel events
`include "uma_settings.svh"

package uma_pkg;

    // Memory command, used per channel and for the shared RAM port
    typedef struct packed {
        logic [`UMA_ADDR_W-1:0] addr;
        logic [`UMA_DATA_W-1:0] din;
        logic [`UMA_SIZE_W-1:0] size;   // Access size code
        logic                   oe_n;
        logic                   we_n;
        logic                   rfsh_n;
    } ram_cmd_t;

    // Shared RAM answer
    typedef struct packed {
        logic [`UMA_DATA_W-1:0] dout;
        logic                   ack_n;
    } ram_rsp_t;

    // What a channel sees back
    typedef struct packed {
        logic [`UMA_DATA_W-1:0] dout;
        logic                   ack_n;
        logic                   wait_n;
    } chan_rsp_t;

    // Request held by a decoder until its slot
    typedef struct packed {
        logic                   pending_oe;
        logic                   pending_we;
        logic                   pending_rfsh;
        logic [`UMA_ADDR_W-1:0] addr;
        logic [`UMA_DATA_W-1:0] din;
        logic [`UMA_SIZE_W-1:0] size;
    } chan_req_t;

    // One-cycle pulses from the decoder
    typedef struct packed {
        logic new_any;  // Any new falling strobe
        logic new_rw;   // New OE_n or WE_n edge
    } chan_event_t;

endpackage

/* source/uma_request_decode.sv */
// UMA request decoder that catches a channel's strobe edges and holds them until served
`timescale 1ns/1ns
`include "uma_settings.svh"

module uma_request_decode (
    input  logic                 CLK,
    input  logic                 RESET_n,
    input  uma_pkg::ram_cmd_t    cmd,
    input  logic                 taken,
    output uma_pkg::chan_req_t   req,
    output uma_pkg::chan_event_t evt
);

    logic                   prev_oe_n;
    logic                   prev_we_n;
    logic                   prev_rfsh_n;
    logic                   det_oe;
    logic                   det_we;
    logic                   det_rfsh;
    logic                   det_rw;
    logic                   save_oe;
    logic                   save_we;
    logic                   save_rfsh;
    logic [`UMA_ADDR_W-1:0] save_addr;
    logic [`UMA_DATA_W-1:0] save_din;
    logic [`UMA_SIZE_W-1:0] save_size;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev_oe_n   <= 1'b1;
            prev_we_n   <= 1'b1;
            prev_rfsh_n <= 1'b1;
        end else begin
            prev_oe_n   <= cmd.oe_n;
            prev_we_n   <= cmd.we_n;
            prev_rfsh_n <= cmd.rfsh_n;
        end
    end

    // High to low transitions
    assign det_oe   = prev_oe_n & ~cmd.oe_n;
    assign det_we   = prev_we_n & ~cmd.we_n;
    assign det_rfsh = prev_rfsh_n & ~cmd.rfsh_n;
    assign det_rw   = det_oe | det_we;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            save_oe   <= 1'b0;
            save_we   <= 1'b0;
            save_rfsh <= 1'b0;
        end else if (taken) begin   // Slot consumed whatever was pending
            save_oe   <= 1'b0;
            save_we   <= 1'b0;
            save_rfsh <= 1'b0;
        end else begin
            save_oe   <= save_oe | det_oe;      // Repeats merge
            save_we   <= save_we | det_we;
            save_rfsh <= save_rfsh | det_rfsh;
        end
    end

    // Latest address and data win
    always_ff @(posedge CLK) begin
        if (det_rw) begin
            save_addr <= cmd.addr;
            save_size <= cmd.size;
        end
        if (det_we)
            save_din <= cmd.din;
    end

    // Live values in the edge cycle so a slot can take them at once
    always_comb begin
        req.pending_oe   = det_oe | save_oe;
        req.pending_we   = det_we | save_we;
        req.pending_rfsh = det_rfsh | save_rfsh;
        req.addr         = det_rw ? cmd.addr : save_addr;
        req.din          = det_we ? cmd.din : save_din;
        req.size         = det_rw ? cmd.size : save_size;
    end

    assign evt.new_any = det_rw | det_rfsh;
    assign evt.new_rw  = det_rw;

endmodule

/* source/uma_slot_execute.sv */
// UMA slot executor that times the channel slots and issues commands to the shared RAM
`timescale 1ns/1ns
`include "uma_settings.svh"

module uma_slot_execute (
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  logic                   CLK_EN,
    input  uma_pkg::chan_req_t     ch0_req,
    input  uma_pkg::chan_req_t     ch1_req,
    input  logic [`UMA_ADDR_W-1:0] ch0_offset,
    input  logic [`UMA_ADDR_W-1:0] ch1_offset,
    input  uma_pkg::ram_rsp_t      ram_rsp,
    output uma_pkg::ram_cmd_t      ram_cmd,
    output logic [1:0]             grant,
    output logic [1:0]             taken,
    output logic                   done
);

    localparam int CNT_W    = $clog2(`UMA_DIV);
    localparam int DLY_W    = `UMA_EXEC_DELAY;
    localparam int SLOT_GAP = `UMA_DIV / 3;     // Three slots per period

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UMA_DIV - 1);
    localparam logic [CNT_W-1:0] SLOT_A   = CNT_W'(`UMA_SLOT_OFFSET);
    localparam logic [CNT_W-1:0] SLOT_B   = CNT_W'(`UMA_SLOT_OFFSET + SLOT_GAP);
    localparam logic [CNT_W-1:0] SLOT_C   = CNT_W'(`UMA_SLOT_OFFSET + 2 * SLOT_GAP);

    logic [CNT_W-1:0]       cnt;
    logic                   slot_hit;
    logic                   toggle;
    logic [1:0]             slot;
    logic [DLY_W-1:0]       dly [2];
    logic [1:0]             exec;
    logic [1:0]             pending;
    uma_pkg::chan_req_t     sel_req;
    logic [`UMA_ADDR_W-1:0] sel_offset;
    logic                   sel_rw;
    logic [`UMA_ADDR_W-1:0] cmd_addr;
    logic [`UMA_DATA_W-1:0] cmd_din;
    logic [`UMA_SIZE_W-1:0] cmd_size;
    logic                   cmd_oe_n;
    logic                   cmd_we_n;
    logic                   cmd_rfsh_n;

    // Restarts on every CLK_EN, parks at the last count
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            cnt <= '0;
        else if (CLK_EN)
            cnt <= '0;
        else if (cnt != CNT_LAST)
            cnt <= cnt + 1'b1;
    end

    assign slot_hit = (cnt == SLOT_A) | (cnt == SLOT_B) | (cnt == SLOT_C);

    // Toggle keeps alternating across periods
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            slot   <= 2'b00;
            toggle <= 1'b0;
        end else begin
            slot <= {slot_hit & toggle, slot_hit & ~toggle};
            if (slot_hit)
                toggle <= ~toggle;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            dly[0] <= '0;
            dly[1] <= '0;
        end else begin
            dly[0] <= (dly[0] << 1) | DLY_W'(slot[0]);
            dly[1] <= (dly[1] << 1) | DLY_W'(slot[1]);
        end
    end

    assign exec[0] = dly[0][DLY_W-1];
    assign exec[1] = dly[1][DLY_W-1];

    assign pending[0] = ch0_req.pending_oe | ch0_req.pending_we | ch0_req.pending_rfsh;
    assign pending[1] = ch1_req.pending_oe | ch1_req.pending_we | ch1_req.pending_rfsh;

    // Channel 0 first if two execution points ever meet
    assign grant[0] = exec[0] & pending[0];
    assign grant[1] = exec[1] & pending[1] & ~grant[0];
    assign taken[0] = exec[0];
    assign taken[1] = exec[1] & ~grant[0];
    assign done     = exec[0] | exec[1];   // Ends the previous slot's access

    assign sel_req    = grant[0] ? ch0_req : ch1_req;
    assign sel_offset = grant[0] ? ch0_offset : ch1_offset;
    assign sel_rw     = sel_req.pending_oe | sel_req.pending_we;

    // Refresh alone goes out with a zero address
    always_ff @(posedge CLK) begin
        if (|grant) begin
            cmd_addr <= sel_rw ? sel_req.addr + sel_offset : '0;   // Wraps modulo 2^24
            cmd_din  <= sel_rw ? sel_req.din : '0;
            cmd_size <= sel_rw ? sel_req.size : '0;
        end
    end

    // A fresh grant wins over a late acknowledge
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            cmd_oe_n   <= 1'b1;
            cmd_we_n   <= 1'b1;
            cmd_rfsh_n <= 1'b1;
        end else if (|grant) begin
            cmd_oe_n   <= ~sel_req.pending_oe;
            cmd_we_n   <= ~sel_req.pending_we;
            cmd_rfsh_n <= ~sel_req.pending_rfsh;
        end else if (!ram_rsp.ack_n) begin
            cmd_oe_n   <= 1'b1;
            cmd_we_n   <= 1'b1;
            cmd_rfsh_n <= 1'b1;
        end
    end

    assign ram_cmd = '{addr: cmd_addr, din: cmd_din, size: cmd_size,
                       oe_n: cmd_oe_n, we_n: cmd_we_n, rfsh_n: cmd_rfsh_n};

endmodule

/* source/uma_channel_result.sv */
// UMA channel result that tracks one channel's access and drives DOUT, ACK_n and WAIT_n
`timescale 1ns/1ns
`include "uma_settings.svh"

module uma_channel_result (
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  logic                   WAIT_EN,
    input  uma_pkg::chan_event_t   evt,
    input  logic                   grant,
    input  logic                   done,
    input  logic [`UMA_DATA_W-1:0] ram_dout,
    output uma_pkg::chan_rsp_t     rsp
);

    logic                   processing;
    logic                   newer;      // Edge seen since the last grant
    logic                   done_ch;
    logic [`UMA_DATA_W-1:0] dout;
    logic                   ack_n;
    logic                   wait_n;

    assign done_ch = done & processing;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            processing <= 1'b0;
        else if (grant)
            processing <= 1'b1;
        else if (done_ch)
            processing <= 1'b0;
    end

    // An edge in the grant cycle rides along with that grant
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            newer <= 1'b0;
        else if (grant)
            newer <= 1'b0;
        else if (evt.new_any)
            newer <= 1'b1;
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            dout <= '0;
        else if (done_ch)
            dout <= ram_dout;   // RAM keeps it until the next command
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            ack_n <= 1'b1;
        else if (evt.new_any)
            ack_n <= 1'b0;
        else if (done_ch && !newer)
            ack_n <= 1'b1;      // Nothing left behind it
    end

    // Refresh alone never stalls the channel
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            wait_n <= 1'b1;
        else if (!WAIT_EN)
            wait_n <= 1'b1;
        else if (evt.new_rw)
            wait_n <= 1'b0;
        else if (done_ch && !newer)
            wait_n <= 1'b1;
    end

    assign rsp = '{dout: dout, ack_n: ack_n, wait_n: wait_n};

endmodule

/* source/uma_arbiter.sv */
// UMA arbiter top that shares one RAM port between two channels
`timescale 1ns/1ns
`include "uma_settings.svh"

module uma_arbiter (
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  logic                   CLK_EN,     // Slow CPU clock enable
    input  logic                   WAIT_EN,
    input  uma_pkg::ram_cmd_t      ch0_cmd,
    input  uma_pkg::ram_cmd_t      ch1_cmd,
    input  logic [`UMA_ADDR_W-1:0] ch0_offset,
    input  logic [`UMA_ADDR_W-1:0] ch1_offset,
    input  uma_pkg::ram_rsp_t      ram_rsp,
    output uma_pkg::ram_cmd_t      ram_cmd,
    output uma_pkg::chan_rsp_t     ch0_rsp,
    output uma_pkg::chan_rsp_t     ch1_rsp
);

    uma_pkg::chan_req_t   ch0_req;
    uma_pkg::chan_req_t   ch1_req;
    uma_pkg::chan_event_t ch0_evt;
    uma_pkg::chan_event_t ch1_evt;
    logic [1:0]           grant;
    logic [1:0]           taken;
    logic                 done;

    // Main memory side
    uma_request_decode dec0_i (
        .CLK(CLK), .RESET_n(RESET_n), .cmd(ch0_cmd), .taken(taken[0]),
        .req(ch0_req), .evt(ch0_evt)
    );

    // Video memory side
    uma_request_decode dec1_i (
        .CLK(CLK), .RESET_n(RESET_n), .cmd(ch1_cmd), .taken(taken[1]),
        .req(ch1_req), .evt(ch1_evt)
    );

    uma_slot_execute exec_i (
        .CLK(CLK), .RESET_n(RESET_n), .CLK_EN(CLK_EN),
        .ch0_req(ch0_req), .ch1_req(ch1_req),
        .ch0_offset(ch0_offset), .ch1_offset(ch1_offset),
        .ram_rsp(ram_rsp), .ram_cmd(ram_cmd),
        .grant(grant), .taken(taken), .done(done)
    );

    uma_channel_result res0_i (
        .CLK(CLK), .RESET_n(RESET_n), .WAIT_EN(WAIT_EN), .evt(ch0_evt),
        .grant(grant[0]), .done(done), .ram_dout(ram_rsp.dout), .rsp(ch0_rsp)
    );

    uma_channel_result res1_i (
        .CLK(CLK), .RESET_n(RESET_n), .WAIT_EN(WAIT_EN), .evt(ch1_evt),
        .grant(grant[1]), .done(done), .ram_dout(ram_rsp.dout), .rsp(ch1_rsp)
    );

endmodule

/* verif/uma_tb.sv */
// UMA arbiter testbench with LFSR requests on both channels, a RAM model and checks
`timescale 1ns/1ns
`include "uma_settings.svh"

module uma_tb;

    localparam int TX_PER_CHAN = 20;                // Per channel and per phase
    localparam int TX_TOTAL    = TX_PER_CHAN * 4;   // Two channels, two phases
    localparam int ADDR_W      = `UMA_ADDR_W;
    localparam int SIZE_W      = `UMA_SIZE_W;

    logic                   CLK;
    logic                   RESET_n;
    logic                   CLK_EN;
    logic                   WAIT_EN;
    uma_pkg::ram_cmd_t      ch_cmd [2];
    uma_pkg::chan_rsp_t     ch_rsp [2];
    logic [`UMA_ADDR_W-1:0] off [2];
    uma_pkg::ram_rsp_t      ram_rsp;
    uma_pkg::ram_cmd_t      ram_cmd;
    uma_pkg::ram_cmd_t      want_cmd [2];
    logic                   want_valid [2];
    logic [`UMA_DATA_W-1:0] mem [logic [`UMA_ADDR_W-1:0]];     // RAM model contents
    logic [`UMA_DATA_W-1:0] ref_mem [logic [`UMA_ADDR_W-1:0]]; // Expected contents
    logic [31:0]            lfsr = 32'hd3a6e95d;
    int                     sch_cnt;        // Own copy of the slot counter
    logic                   sch_toggle;
    logic                   last_owner;     // Channel of the latest slot
    int                     en_cnt;
    logic                   strb_idle;

    uma_arbiter dut_i (
        .CLK(CLK), .RESET_n(RESET_n), .CLK_EN(CLK_EN), .WAIT_EN(WAIT_EN),
        .ch0_cmd(ch_cmd[0]), .ch1_cmd(ch_cmd[1]), .ch0_offset(off[0]), .ch1_offset(off[1]),
        .ram_rsp(ram_rsp), .ram_cmd(ram_cmd), .ch0_rsp(ch_rsp[0]), .ch1_rsp(ch_rsp[1])
    );

    assign strb_idle = ram_cmd.oe_n & ram_cmd.we_n & ram_cmd.rfsh_n;

    task automatic stop_with_failure(input string text);
        $display("%s", text);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] want,
                                input logic [63:0] got);
        stop_with_failure($sformatf("** Error: %s: expected %0h, actual %0h", name, want, got));
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`UMA_DATA_W-1:0] fill_word(input logic [`UMA_ADDR_W-1:0] a);
        return {a, a[23:16]} ^ 32'h9e3779b9;
    endfunction

    function automatic uma_pkg::ram_cmd_t idle_cmd();
        return '{addr: '0, din: '0, size: '0, oe_n: 1'b1, we_n: 1'b1, rfsh_n: 1'b1};
    endfunction

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // CLK_EN pulse every UMA_DIV clocks from reset release
    always @(negedge CLK) begin
        en_cnt <= (!RESET_n || en_cnt == `UMA_DIV - 1) ? 0 : en_cnt + 1;
        CLK_EN <= RESET_n && (en_cnt == `UMA_DIV - 1);
    end

    // Slot schedule from the timing rules, to know who owns each command
    always @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sch_cnt    <= 0;
            sch_toggle <= 1'b0;
            last_owner <= 1'b0;
        end else begin
            if (sch_cnt == `UMA_SLOT_OFFSET || sch_cnt == `UMA_SLOT_OFFSET + 10 ||
                sch_cnt == `UMA_SLOT_OFFSET + 20) begin
                last_owner <= sch_toggle;
                sch_toggle <= ~sch_toggle;
            end
            if (CLK_EN)
                sch_cnt <= 0;
            else if (sch_cnt != `UMA_DIV - 1)
                sch_cnt <= sch_cnt + 1;
        end
    end

    // RAM model answers on the falling edge
    always @(negedge CLK) begin
        uma_pkg::ram_cmd_t got;
        ram_rsp.ack_n <= strb_idle;
        if (RESET_n && !strb_idle) begin
            got = ram_cmd;
            if (!want_valid[last_owner])
                stop_with_failure($sformatf("RAM command without a request on channel %0d",
                                            last_owner));
            if (!want_cmd[last_owner].oe_n)
                got.din = want_cmd[last_owner].din;     // Read data field is don't care
            assert (got == want_cmd[last_owner])
                else report_value($sformatf("ram_cmd_ch%0d", last_owner),
                                  64'(want_cmd[last_owner]), 64'(got));
            want_valid[last_owner] = 1'b0;
            if (!ram_cmd.we_n)
                mem[ram_cmd.addr] = ram_cmd.din;
            if (!ram_cmd.oe_n)
                ram_rsp.dout <= mem.exists(ram_cmd.addr) ? mem[ram_cmd.addr] :
                                fill_word(ram_cmd.addr);
        end
    end

    assert property (@(posedge CLK) disable iff (!RESET_n) !strb_idle |=> strb_idle)
        else stop_with_failure("RAM strobe held low for more than one cycle");

    assert property (@(posedge CLK) disable iff (!RESET_n) $fell(strb_idle) |->
                     (sch_cnt == `UMA_SLOT_OFFSET + 4 || sch_cnt == `UMA_SLOT_OFFSET + 14 ||
                      sch_cnt == `UMA_SLOT_OFFSET + 24))
        else stop_with_failure("RAM strobe fell outside a slot command point");

    assert property (@(posedge CLK) disable iff (!RESET_n)
                     !WAIT_EN |=> (ch_rsp[0].wait_n && ch_rsp[1].wait_n))
        else stop_with_failure("WAIT_n went low while WAIT_EN was low");

    task automatic run_channel(input int ch, input int count);
        int                     kind;
        logic [`UMA_ADDR_W-1:0] addr;
        logic [`UMA_ADDR_W-1:0] phys;
        logic [`UMA_ADDR_W-1:0] last_wr;
        logic                   has_wr;
        logic                   saw_wait;
        logic [`UMA_DATA_W-1:0] want_dout;
        uma_pkg::ram_cmd_t      cmd;
        uma_pkg::ram_cmd_t      want;
        has_wr  = 1'b0;
        last_wr = '0;
        for (int i = 0; i < count; i++) begin
            kind = take_bits(2);       // 0 and 1 write, 2 read, 3 refresh
            cmd  = idle_cmd();
            cmd.addr = ADDR_W'(take_bits(24));
            cmd.din  = take_bits(32);
            cmd.size = SIZE_W'(take_bits(2));
            if (kind == 2 && has_wr && take_bits(1))
                cmd.addr = last_wr;
            addr = cmd.addr;
            phys = addr + off[ch];
            want = '{addr: phys, din: cmd.din, size: cmd.size,
                     oe_n: 1'b1, we_n: 1'b1, rfsh_n: 1'b1};
            if (kind < 2) begin
                cmd.we_n  = 1'b0;
                want.we_n = 1'b0;
            end else if (kind == 2) begin
                cmd.oe_n  = 1'b0;
                want.oe_n = 1'b0;
            end else begin
                cmd.rfsh_n = 1'b0;
                want = '{addr: '0, din: '0, size: '0, oe_n: 1'b1, we_n: 1'b1, rfsh_n: 1'b0};
            end
            want_cmd[ch]   = want;
            want_valid[ch] = 1'b1;
            @(negedge CLK);
            ch_cmd[ch] = cmd;
            @(negedge CLK);
            ch_cmd[ch] = idle_cmd();
            assert (!ch_rsp[ch].ack_n)
                else report_value("ack_low", 0, 64'(ch_rsp[ch].ack_n));
            saw_wait = !ch_rsp[ch].wait_n;
            while (!ch_rsp[ch].ack_n) begin
                @(negedge CLK);
                if (!ch_rsp[ch].wait_n)
                    saw_wait = 1'b1;
            end
            if (want_valid[ch])
                stop_with_failure("Request completed without a RAM command");
            assert (ch_rsp[ch].wait_n) else report_value("wait_release", 1, 0);
            assert (saw_wait == (WAIT_EN && kind != 3))
                else report_value("wait_low", 64'(WAIT_EN && kind != 3), 64'(saw_wait));
            if (kind < 2) begin
                ref_mem[phys] = cmd.din;
                last_wr = addr;
                has_wr  = 1'b1;
            end else if (kind == 2) begin
                want_dout = ref_mem.exists(phys) ? ref_mem[phys] : fill_word(phys);
                assert (ch_rsp[ch].dout == want_dout)
                    else report_value($sformatf("read_data_ch%0d", ch), 64'(want_dout),
                                      64'(ch_rsp[ch].dout));
            end
        end
    endtask

    initial begin
        #(TX_TOTAL * 2 * `UMA_DIV * 4 + 2000);
        stop_with_failure("Watchdog timeout, a request never completed");
    end

    initial begin
        RESET_n       = 1'b0;
        CLK_EN        = 1'b0;
        WAIT_EN       = 1'b1;
        en_cnt        = 0;
        ch_cmd[0]     = idle_cmd();
        ch_cmd[1]     = idle_cmd();
        ram_rsp       = '{dout: '0, ack_n: 1'b1};
        want_valid[0] = 1'b0;
        want_valid[1] = 1'b0;
        off[0]        = ADDR_W'(take_bits(24));
        off[1]        = ADDR_W'(take_bits(24));
        repeat (5) @(negedge CLK);
        RESET_n <= 1'b1;
        assert (strb_idle && ch_rsp[0].ack_n && ch_rsp[1].ack_n &&
                ch_rsp[0].wait_n && ch_rsp[1].wait_n)
            else stop_with_failure("Strobes or handshakes not high after reset");
        assert (ch_rsp[0].dout == 0 && ch_rsp[1].dout == 0)
            else report_value("reset_dout", 0, {ch_rsp[1].dout, ch_rsp[0].dout});
        fork
            run_channel(0, TX_PER_CHAN);
            run_channel(1, TX_PER_CHAN);
        join
        @(negedge CLK);
        WAIT_EN = 1'b0;     // Second phase without wait states
        fork
            run_channel(0, TX_PER_CHAN);
            run_channel(1, TX_PER_CHAN);
        join
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* uma_arbiter.f */
+incdir+source
source/uma_pkg.sv
source/uma_request_decode.sv
source/uma_slot_execute.sv
source/uma_channel_result.sv
source/uma_arbiter.sv
verif/uma_tb.sv

/* Makefile */
# Verilator build and run for the UMA arbiter testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f uma_arbiter.f --top-module uma_tb \
		-o uma_sim --Mdir obj_dir
	-./obj_dir/uma_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
